//--- all.f
+incdir+dv
hdl/fsync_cfg_pkg.sv
hdl/fsync_msg_pkg.sv
hdl/fsync_node_1d.sv
hdl/fsync_node_root.sv
hdl/fractal_sync_2x2.sv
dv/tb_fractal_sync_2x2.sv

//--- dv/fsync_ref_model.svh
//****************************************************************************
// Reference model of the 2x2 barrier network
// Planned request per CU with its drive cycle, level and id
// Expected answer per CU as sampling edge, kind and id
//****************************************************************************

`ifndef FSYNC_REF_MODEL_SVH
`define FSYNC_REF_MODEL_SVH

logic [N_CU-1:0]          mdl_active;             // CU takes part in the current round
int                       mdl_drv_cyc [N_CU];     // Falling edge cycle that drives the request
fsync_msg_pkg::level_e    mdl_level   [N_CU];
logic [ID_WIDTH-1:0]      mdl_id      [N_CU];     // Request id, also the id of the answer
int                       mdl_exp_cyc [N_CU];     // Rising edge that samples the answer
fsync_msg_pkg::rsp_kind_e mdl_kind    [N_CU];

function automatic void model_clear();
  for (int c = 0; c < N_CU; c++) begin
    mdl_active[c]  = 1'b0;
    mdl_drv_cyc[c] = 0;
    mdl_level[c]   = fsync_msg_pkg::LVL_NONE;
    mdl_id[c]      = '0;
    mdl_exp_cyc[c] = 0;
    mdl_kind[c]    = fsync_msg_pkg::RSP_WAKE;
  end
endfunction

function automatic void model_plan(int c, fsync_msg_pkg::level_e lvl,
                                   logic [ID_WIDTH-1:0] id, int drv);
  mdl_active[c]  = 1'b1;
  mdl_level[c]   = lvl;
  mdl_id[c]      = id;
  mdl_drv_cyc[c] = drv;
endfunction

// A request driven on a falling edge is sampled by the next rising edge
function automatic int sample_edge(int c);
  return mdl_drv_cyc[c] + 1;
endfunction

function automatic int max_int(int a, int b);
  return (a > b) ? a : b;
endfunction

function automatic void model_resolve();
  int last_quad;
  int p;
  last_quad = 0;
  for (int c = 0; c < N_CU; c++) begin
    if (mdl_active[c] && mdl_level[c] == fsync_msg_pkg::LVL_QUAD) begin
      last_quad = max_int(last_quad, sample_edge(c));  // The last arrival anywhere decides
    end
  end
  for (int c = 0; c < N_CU; c++) begin
    p = c ^ 1;  // Partner CU in the same 1D node
    if (mdl_active[c]) begin
      if (!fsync_msg_pkg::level_valid(mdl_level[c])) begin
        mdl_exp_cyc[c] = sample_edge(c) + 1;
        mdl_kind[c]    = fsync_msg_pkg::RSP_ERROR;
      end else if (mdl_level[c] == fsync_msg_pkg::LVL_PAIR) begin
        mdl_exp_cyc[c] = max_int(sample_edge(c), sample_edge(p)) + 1;
        mdl_kind[c]    = fsync_msg_pkg::RSP_WAKE;
      end else begin
        mdl_exp_cyc[c] = last_quad + 3;  // Node up, root down, node wake
        mdl_kind[c]    = fsync_msg_pkg::RSP_WAKE;
      end
    end
  end
endfunction

function automatic logic exp_strobe(int c, int edge_cyc, fsync_msg_pkg::rsp_kind_e kind);
  return mdl_active[c] && (mdl_exp_cyc[c] == edge_cyc) && (mdl_kind[c] == kind);
endfunction

function automatic logic [ID_WIDTH-1:0] exp_rsp_id(int c, int edge_cyc);
  if (mdl_active[c] && (mdl_exp_cyc[c] == edge_cyc)) begin
    return mdl_id[c];
  end
  return '0;  // Idle response port shows id zero
endfunction

`endif

//--- dv/tb_fractal_sync_2x2.sv
//****************************************************************************
// Testbench of the 2x2 fractal synchronization network
// Clock, reset and xorshift driven pair, quad and error rounds
// Cycle by cycle comparison of every CU response against the model
// Cycle limit that ends a hanging run
//****************************************************************************

module tb_fractal_sync_2x2;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned N_CU     = fsync_cfg_pkg::N_CU;
  localparam int unsigned ID_WIDTH = fsync_cfg_pkg::DEFAULT_ID_WIDTH;
  localparam int N_IDS          = 2 ** ID_WIDTH;
  localparam int N_ROUNDS       = 200;
  localparam int ROUND_CYCLES   = 12;                            // Generous bound per round
  localparam int TIMEOUT_CYCLES = N_ROUNDS * ROUND_CYCLES + 50;

  logic                                 clk;
  logic                                 rst_n;
  logic [N_CU-1:0]                      req_valid;
  fsync_msg_pkg::level_e [N_CU-1:0]     req_level;
  logic [N_CU-1:0][ID_WIDTH-1:0]        req_id;
  logic [N_CU-1:0]                      rsp_wake;
  logic [N_CU-1:0]                      rsp_error;
  logic [N_CU-1:0][ID_WIDTH-1:0]        rsp_id;

  int          cyc;        // Rising edges seen so far
  logic [31:0] rng_state;

  `include "fsync_ref_model.svh"

  fractal_sync_2x2 #(
    .ID_WIDTH ( ID_WIDTH )
  ) uut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .req_valid_i ( req_valid ),
    .req_level_i ( req_level ),
    .req_id_i    ( req_id    ),
    .rsp_wake_o  ( rsp_wake  ),
    .rsp_error_o ( rsp_error ),
    .rsp_id_o    ( rsp_id    )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Timeout: barrier answers still missing after %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "run stopped at the cycle limit");
    end
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int rand_below(int n);
    rng_state = xorshift32(rng_state);
    return int'(rng_state % 32'(n));
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s at cycle %0d: got 0x%0h, expected 0x%0h", name, cyc, got, exp);
      $display("Test failed");
      $fatal(1, "response mismatch");
    end
  endtask

  // Values seen on a falling edge are the ones that the next rising edge samples
  task automatic compare_outputs();
    int edge_cyc;
    edge_cyc = cyc + 1;
    for (int c = 0; c < N_CU; c++) begin
      check_value($sformatf("rsp_wake_o[%0d]", c), 32'(rsp_wake[c]),
                  32'(exp_strobe(c, edge_cyc, fsync_msg_pkg::RSP_WAKE)));
      check_value($sformatf("rsp_error_o[%0d]", c), 32'(rsp_error[c]),
                  32'(exp_strobe(c, edge_cyc, fsync_msg_pkg::RSP_ERROR)));
      check_value($sformatf("rsp_id_o[%0d]", c), 32'(rsp_id[c]), 32'(exp_rsp_id(c, edge_cyc)));
    end
  endtask

  task automatic drive_requests();
    for (int c = 0; c < N_CU; c++) begin
      if (mdl_active[c] && mdl_drv_cyc[c] == cyc) begin
        req_valid[c] = 1'b1;
        req_level[c] = mdl_level[c];
        req_id[c]    = mdl_id[c];
      end else begin
        req_valid[c] = 1'b0;
        req_level[c] = fsync_msg_pkg::LVL_NONE;
        req_id[c]    = '0;
      end
    end
  endtask

  // Both CUs of one 1D node meet at a random id with their own delays
  task automatic plan_pair(input int node, input int base);
    logic [ID_WIDTH-1:0] id;
    id = ID_WIDTH'(rand_below(N_IDS));
    for (int c = 2 * node; c < 2 * node + 2; c++) begin
      model_plan(c, fsync_msg_pkg::LVL_PAIR, id, base + rand_below(4));
    end
  endtask

  task automatic run_round(input int kind);
    logic [N_CU-1:0]       answered;
    logic [ID_WIDTH-1:0]   id;
    fsync_msg_pkg::level_e bad_lvl;
    int                    base;
    int                    e;
    base = cyc + 1;  // First falling edge of this round
    model_clear();
    if (kind == 0) begin
      plan_pair(0, base);
      plan_pair(1, base);
    end else if (kind == 1) begin
      id = ID_WIDTH'(rand_below(N_IDS));
      for (int c = 0; c < N_CU; c++) begin
        model_plan(c, fsync_msg_pkg::LVL_QUAD, id, base + rand_below(4));
      end
    end else begin
      e       = rand_below(N_CU);
      bad_lvl = rand_below(2) ? fsync_msg_pkg::LVL_RSVD : fsync_msg_pkg::LVL_NONE;
      id      = ID_WIDTH'(rand_below(N_IDS));
      model_plan(e, bad_lvl, id, base + rand_below(4));
      plan_pair(1 - e / 2, base);  // Barrier pending in the other node meanwhile
    end
    model_resolve();
    answered = '0;
    while ((answered & mdl_active) != mdl_active) begin
      @(negedge clk);
      compare_outputs();
      drive_requests();
      answered = answered | rsp_wake | rsp_error;
    end
  endtask

  initial begin
    int kind;
    int last_cu;
    cyc       = 0;
    rng_state = 32'h0e361f19;
    rst_n     = 1'b0;
    req_valid = '0;
    req_id    = '0;
    for (int c = 0; c < N_CU; c++) begin
      req_level[c] = fsync_msg_pkg::LVL_NONE;
    end
    model_clear();
    repeat (2) @(posedge clk);
    @(negedge clk);
    compare_outputs();
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      compare_outputs();  // Idle network after reset
    end
    for (int r = 0; r < N_ROUNDS; r++) begin
      kind = rand_below(3);
      run_round(kind);
      if (r % 50 == 49) begin
        last_cu = 0;
        for (int c = 0; c < N_CU; c++) begin
          if (mdl_active[c]) last_cu = c;
        end
        $display("Round %0d done, CU%0d answered with %s", r + 1, last_cu,
                 mdl_kind[last_cu].name());
      end
    end
    repeat (4) begin
      @(negedge clk);
      compare_outputs();  // No late or stray strobes
      drive_requests();
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule : tb_fractal_sync_2x2

//--- hdl/fractal_sync_2x2.sv
//**************************************************************************
// Top level of the 2x2 fractal synchronization network
// Two horizontal 1D nodes, CU0/CU1 and CU2/CU3, joined by one root node
// The root answer fans out to both 1D nodes
//**************************************************************************

module fractal_sync_2x2 #(
  parameter int unsigned ID_WIDTH = fsync_cfg_pkg::DEFAULT_ID_WIDTH
) (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  input  logic                  [fsync_cfg_pkg::N_CU-1:0]    req_valid_i,
  input  fsync_msg_pkg::level_e [fsync_cfg_pkg::N_CU-1:0]    req_level_i,
  input  logic [fsync_cfg_pkg::N_CU-1:0][ID_WIDTH-1:0]       req_id_i,
  output logic                  [fsync_cfg_pkg::N_CU-1:0]    rsp_wake_o,
  output logic                  [fsync_cfg_pkg::N_CU-1:0]    rsp_error_o,
  output logic [fsync_cfg_pkg::N_CU-1:0][ID_WIDTH-1:0]       rsp_id_o
);

  localparam int unsigned CPN = fsync_cfg_pkg::N_CU_PER_NODE;  // CU slice per 1D node

  logic [fsync_cfg_pkg::N_NODES_1D-1:0]               up_valid;  // 1D node to root
  logic [fsync_cfg_pkg::N_NODES_1D-1:0][ID_WIDTH-1:0] up_id;
  logic                                               down_valid;  // Root to both 1D nodes
  logic [ID_WIDTH-1:0]                                down_id;

  // CU0 and CU1
  fsync_node_1d #(
    .ID_WIDTH ( ID_WIDTH )
  ) i_node_1d_0 (
    .clk_i        ( clk_i                  ),
    .rst_n_i      ( rst_n_i                ),
    .req_valid_i  ( req_valid_i[CPN-1:0]   ),
    .req_level_i  ( req_level_i[CPN-1:0]   ),
    .req_id_i     ( req_id_i[CPN-1:0]      ),
    .rsp_wake_o   ( rsp_wake_o[CPN-1:0]    ),
    .rsp_error_o  ( rsp_error_o[CPN-1:0]   ),
    .rsp_id_o     ( rsp_id_o[CPN-1:0]      ),
    .up_valid_o   ( up_valid[0]            ),
    .up_id_o      ( up_id[0]               ),
    .down_valid_i ( down_valid             ),
    .down_id_i    ( down_id                )
  );

  // CU2 and CU3
  fsync_node_1d #(
    .ID_WIDTH ( ID_WIDTH )
  ) i_node_1d_1 (
    .clk_i        ( clk_i                      ),
    .rst_n_i      ( rst_n_i                    ),
    .req_valid_i  ( req_valid_i[2*CPN-1:CPN]   ),
    .req_level_i  ( req_level_i[2*CPN-1:CPN]   ),
    .req_id_i     ( req_id_i[2*CPN-1:CPN]      ),
    .rsp_wake_o   ( rsp_wake_o[2*CPN-1:CPN]    ),
    .rsp_error_o  ( rsp_error_o[2*CPN-1:CPN]   ),
    .rsp_id_o     ( rsp_id_o[2*CPN-1:CPN]      ),
    .up_valid_o   ( up_valid[1]                ),
    .up_id_o      ( up_id[1]                   ),
    .down_valid_i ( down_valid                 ),
    .down_id_i    ( down_id                    )
  );

  fsync_node_root #(
    .ID_WIDTH ( ID_WIDTH )
  ) i_root (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .up_valid_i   ( up_valid   ),
    .up_id_i      ( up_id      ),
    .down_valid_o ( down_valid ),
    .down_id_o    ( down_id    )
  );

endmodule : fractal_sync_2x2

//--- hdl/fsync_cfg_pkg.sv
//**************************************************************************
// Network-size constants of the 2x2 fractal synchronization network
// Number of compute units, CUs per 1D node, number of 1D nodes
// Default barrier id width used by the top level
//**************************************************************************

package fsync_cfg_pkg;

  // Four compute units in a 2x2 arrangement
  localparam int unsigned N_CU = 4;

  // Each horizontal 1D node joins two neighbouring CUs
  localparam int unsigned N_CU_PER_NODE = 2;

  // Two horizontal 1D nodes feed the root
  localparam int unsigned N_NODES_1D = 2;

  // Two id bits give four barriers that may be pending at the same time
  localparam int unsigned DEFAULT_ID_WIDTH = 2;

endpackage : fsync_cfg_pkg

//--- hdl/fsync_msg_pkg.sv
//**************************************************************************
// Message encodings of the fractal synchronization network
// Request level opcode and response kind enums
// Helper that tells the supported levels apart from invalid ones
//**************************************************************************

package fsync_msg_pkg;

  // Aggregate level of a barrier request, as carried on the CU port
  typedef enum logic [1:0] {
    LVL_NONE = 2'd0,  // No level given, answered with an error
    LVL_PAIR = 2'd1,  // Barrier between the two CUs of one 1D node
    LVL_QUAD = 2'd2,  // Barrier across all four CUs through the root
    LVL_RSVD = 2'd3   // Reserved encoding, answered with an error
  } level_e;

  // Kind of response that a 1D node returns to a CU
  typedef enum logic {
    RSP_WAKE  = 1'b0,  // Barrier done
    RSP_ERROR = 1'b1   // Request rejected
  } rsp_kind_e;

  // Only PAIR and QUAD are levels that this network can synchronize
  function automatic logic level_valid(level_e lvl);
    return (lvl == LVL_PAIR) || (lvl == LVL_QUAD);
  endfunction

endpackage : fsync_msg_pkg

//--- hdl/fsync_node_1d.sv
//**************************************************************************
// Horizontal 1D barrier node serving two compute units
// Per-id arrival flags for PAIR and QUAD levels
// Answers PAIR barriers and invalid levels locally
// Relays complete QUAD arrivals to the root and wakes both CUs on return
//**************************************************************************

module fsync_node_1d #(
  parameter int unsigned ID_WIDTH = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                   [1:0]         req_valid_i,   // Request strobe per CU
  input  fsync_msg_pkg::level_e  [1:0]         req_level_i,   // Aggregate level per CU
  input  logic                   [1:0][ID_WIDTH-1:0] req_id_i, // Barrier id per CU
  output logic                   [1:0]         rsp_wake_o,    // Barrier done strobe per CU
  output logic                   [1:0]         rsp_error_o,   // Invalid request strobe per CU
  output logic                   [1:0][ID_WIDTH-1:0] rsp_id_o, // Id of the answered request
  output logic                                 up_valid_o,    // Both CUs reached a QUAD barrier
  output logic                   [ID_WIDTH-1:0] up_id_o,
  input  logic                                 down_valid_i,  // Root reports a QUAD barrier done
  input  logic                   [ID_WIDTH-1:0] down_id_i
);

  localparam int unsigned N_IDS = 2 ** ID_WIDTH;  // One flag pair per possible id

  logic [N_IDS-1:0][1:0] pair_arr_q, pair_arr_d;  // PAIR arrivals, indexed by id then CU
  logic [N_IDS-1:0][1:0] quad_arr_q, quad_arr_d;  // QUAD arrivals, indexed by id then CU

  logic                pair_done;     // Both CUs present for one PAIR id this cycle
  logic [ID_WIDTH-1:0] pair_done_id;
  logic                quad_done;     // Both CUs present for one QUAD id this cycle
  logic [ID_WIDTH-1:0] quad_done_id;

  logic [1:0]               rsp_valid_q, rsp_valid_d;  // A response goes out next cycle
  fsync_msg_pkg::rsp_kind_e rsp_kind_q [2];            // Wake or error, qualified by valid
  fsync_msg_pkg::rsp_kind_e rsp_kind_d [2];
  logic [1:0][ID_WIDTH-1:0] rsp_id_q, rsp_id_d;        // Held at zero when nothing is sent

  logic                up_valid_q, up_valid_d;
  logic [ID_WIDTH-1:0] up_id_q, up_id_d;

  // Arrival bookkeeping, the second arrival of an id completes it in the same cycle
  always_comb begin
    pair_arr_d   = pair_arr_q;
    quad_arr_d   = quad_arr_q;
    pair_done    = 1'b0;
    pair_done_id = '0;
    quad_done    = 1'b0;
    quad_done_id = '0;
    for (int c = 0; c < 2; c++) begin
      if (req_valid_i[c]) begin
        if (req_level_i[c] == fsync_msg_pkg::LVL_PAIR) begin
          pair_arr_d[req_id_i[c]][c] = 1'b1;
        end else if (req_level_i[c] == fsync_msg_pkg::LVL_QUAD) begin
          quad_arr_d[req_id_i[c]][c] = 1'b1;
        end
      end
    end
    // Each CU has one request in flight, so at most one id completes per level
    for (int i = 0; i < N_IDS; i++) begin
      if (&pair_arr_d[i]) begin
        pair_arr_d[i] = '0;                // Free the id for the next round
        pair_done     = 1'b1;
        pair_done_id  = ID_WIDTH'(i);
      end
      if (&quad_arr_d[i]) begin
        quad_arr_d[i] = '0;
        quad_done     = 1'b1;
        quad_done_id  = ID_WIDTH'(i);
      end
    end
  end

  // Response selection per CU, a returning QUAD wake takes precedence
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      rsp_valid_d[c] = 1'b0;
      rsp_kind_d[c]  = fsync_msg_pkg::RSP_WAKE;
      rsp_id_d[c]    = '0;
      if (down_valid_i) begin
        rsp_valid_d[c] = 1'b1;  // Both local CUs took part in the QUAD barrier
        rsp_id_d[c]    = down_id_i;
      end else if (pair_done) begin
        rsp_valid_d[c] = 1'b1;
        rsp_id_d[c]    = pair_done_id;
      end else if (req_valid_i[c] && !fsync_msg_pkg::level_valid(req_level_i[c])) begin
        rsp_valid_d[c] = 1'b1;  // Rejected right away, no flag is touched
        rsp_kind_d[c]  = fsync_msg_pkg::RSP_ERROR;
        rsp_id_d[c]    = req_id_i[c];
      end
    end
    up_valid_d = quad_done;
    up_id_d    = quad_done_id;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pair_arr_q  <= '0;
      quad_arr_q  <= '0;
      rsp_valid_q <= '0;
      rsp_id_q    <= '0;  // The CU port shows id zero while idle
      up_valid_q  <= 1'b0;
      up_id_q     <= '0;
    end else begin
      pair_arr_q  <= pair_arr_d;
      quad_arr_q  <= quad_arr_d;
      rsp_valid_q <= rsp_valid_d;
      rsp_id_q    <= rsp_id_d;
      up_valid_q  <= up_valid_d;
      up_id_q     <= up_id_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_kind_q <= rsp_kind_d;
  end

  for (genvar c = 0; c < 2; c++) begin : gen_rsp
    assign rsp_wake_o[c]  = rsp_valid_q[c] && (rsp_kind_q[c] == fsync_msg_pkg::RSP_WAKE);
    assign rsp_error_o[c] = rsp_valid_q[c] && (rsp_kind_q[c] == fsync_msg_pkg::RSP_ERROR);

    // An invalid request is answered by an error in the next cycle, never dropped for a wake
    a_error_only : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_valid_i[c] && !fsync_msg_pkg::level_valid(req_level_i[c])
      |=> rsp_error_o[c]);

    // A CU waits for its answer before it arrives again at the same barrier
    a_no_rearrival : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_valid_i[c] |->
      !((req_level_i[c] == fsync_msg_pkg::LVL_PAIR) && pair_arr_q[req_id_i[c]][c]) &&
      !((req_level_i[c] == fsync_msg_pkg::LVL_QUAD) && quad_arr_q[req_id_i[c]][c]));
  end

  assign rsp_id_o   = rsp_id_q;
  assign up_valid_o = up_valid_q;
  assign up_id_o    = up_id_q;

endmodule : fsync_node_1d

//--- hdl/fsync_node_root.sv
//**************************************************************************
// Root barrier node of the 2x2 network
// One arrival flag per 1D node per id
// Returns a single down strobe once both 1D nodes reached an id
//**************************************************************************

module fsync_node_root #(
  parameter int unsigned ID_WIDTH = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [1:0]                up_valid_i,   // QUAD arrival strobe per 1D node
  input  logic [1:0][ID_WIDTH-1:0]  up_id_i,
  output logic                      down_valid_o, // Whole network reached the barrier
  output logic [ID_WIDTH-1:0]       down_id_o
);

  localparam int unsigned N_IDS = 2 ** ID_WIDTH;

  logic [N_IDS-1:0][1:0] arr_q, arr_d;  // Arrival flags, indexed by id then 1D node

  logic                down_valid_q, down_valid_d;
  logic [ID_WIDTH-1:0] down_id_q, down_id_d;

  always_comb begin
    arr_d        = arr_q;
    down_valid_d = 1'b0;
    down_id_d    = '0;
    for (int n = 0; n < 2; n++) begin
      if (up_valid_i[n]) begin
        arr_d[up_id_i[n]][n] = 1'b1;
      end
    end
    // Two nodes reaching different ids together leave both ids half done
    for (int i = 0; i < N_IDS; i++) begin
      if (&arr_d[i]) begin
        arr_d[i]     = '0;
        down_valid_d = 1'b1;
        down_id_d    = ID_WIDTH'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      arr_q        <= '0;
      down_valid_q <= 1'b0;
      down_id_q    <= '0;
    end else begin
      arr_q        <= arr_d;
      down_valid_q <= down_valid_d;
      down_id_q    <= down_id_d;
    end
  end

  assign down_valid_o = down_valid_q;
  assign down_id_o    = down_id_q;

  // A 1D node forwards an id only once per barrier round
  for (genvar n = 0; n < 2; n++) begin : gen_chk
    a_no_double_up : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      up_valid_i[n] |-> !arr_q[up_id_i[n]][n]);
  end

endmodule : fsync_node_root

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it, the log decides the result
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_fractal_sync_2x2 -f all.f -o sim_tb > "$LOG" 2>&1 \
  && ./obj_dir/sim_tb >> "$LOG" 2>&1 \
  || echo "Test failed" >> "$LOG"

cat "$LOG"

grep -q "Test failed" "$LOG" && { echo "Simulation FAILED, see $LOG"; exit 1; }
echo "Simulation PASSED"
exit 0
